// ==== common/capture_cfg_pkg.sv ====
package capture_cfg_pkg;

	// Every other size follows from this one
	localparam int SAMPLE_WIDTH = 3;

	localparam int SAMPLES_PER_WORD = 8;
	localparam int WORD_WIDTH = SAMPLE_WIDTH * SAMPLES_PER_WORD;

	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	// The packer and unpacker work on samples, the RAM stores raw bits
	typedef union packed {
		logic [WORD_WIDTH-1:0] raw;
		sample_t [SAMPLES_PER_WORD-1:0] samples; // Index 0 is the oldest sample
	} ram_word_t;

endpackage

// ==== common/capture_msg_pkg.sv ====
package capture_msg_pkg;

	import capture_cfg_pkg::*;

	typedef enum logic {
		mode_capture = 1'b0,
		mode_playback = 1'b1
	} mode_t;

	// Host command, mode must be stable before req rises
	typedef struct packed {
		logic req;
		mode_t mode;
	} cmd_t;

	typedef struct packed {
		logic ack;
		logic accepted;
		mode_t mode; // Mode in force after the command
	} ack_t;

	typedef struct packed {
		logic valid;
		logic frame_start;
		logic frame_end;
		sample_t sample;
	} play_t;

	typedef struct packed {
		logic valid;
		sample_t sample;
	} in_sample_t;

endpackage

// ==== logic/capture_sequencer.sv ====
`timescale 1ns/1ps

module capture_sequencer
	import capture_msg_pkg::*;
(
	input logic clk,
	input logic reset,
	input cmd_t cmd,
	input logic frame_full,
	output ack_t ack,
	output logic capture_en,
	output logic clear,
	output logic play_en,
	output logic play_restart
);

	typedef enum logic [2:0] {
		st_capture,
		st_flush,
		st_play_prep,
		st_play,
		st_ack_hold
	} state_t;

	state_t state;
	logic idle;

	assign idle = (state == st_capture) || (state == st_play); // Only here is req sampled

	assign clear = idle && cmd.req && (cmd.mode == mode_capture);
	assign play_restart = (state == st_flush);
	assign capture_en = (ack.mode == mode_capture) &&
		((state == st_capture) || (state == st_ack_hold));
	assign play_en = (ack.mode == mode_playback) &&
		((state == st_play) || (state == st_ack_hold));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_capture;
			ack <= '{ack: 1'b0, accepted: 1'b0, mode: mode_capture};
		end else begin
			case (state)
				st_capture, st_play: begin
					if (cmd.req) begin
						if (cmd.mode == mode_capture) begin
							state <= st_ack_hold;
							ack <= '{ack: 1'b1, accepted: 1'b1, mode: mode_capture};
						end else if (frame_full) begin
							state <= st_flush;
						end else begin
							state <= st_ack_hold; // Refused with the mode unchanged
							ack <= '{ack: 1'b1, accepted: 1'b0, mode: ack.mode};
						end
					end
				end
				st_flush: state <= st_play_prep; // Partial word dropped here
				st_play_prep: begin
					state <= st_ack_hold; // First read is in flight
					ack <= '{ack: 1'b1, accepted: 1'b1, mode: mode_playback};
				end
				st_ack_hold: begin
					if (!cmd.req) begin
						ack.ack <= 1'b0;
						state <= (ack.mode == mode_playback) ? st_play : st_capture;
					end
				end
				default: state <= st_capture;
			endcase
		end
	end

	// Ack only rises in answer to a pending req
	assert property (@(posedge clk) disable iff (reset)
		$rose(ack.ack) |-> $past(cmd.req));

endmodule

// ==== logic/frame_counter.sv ====
`timescale 1ns/1ps

module frame_counter #(
	parameter int NUM_WORDS = 16,
	parameter int FRAME_WORDS = 4,
	localparam int AW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1,
	localparam int IW = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1,
	localparam int CW = $clog2(FRAME_WORDS + 1)
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic word_valid,
	input logic play_restart,
	input logic word_take,
	output logic [AW-1:0] write_addr,
	output logic [AW-1:0] read_addr,
	output logic [IW-1:0] play_index,
	output logic frame_full
);

	logic [AW-1:0] start_addr;
	logic [AW-1:0] start_next;
	logic [CW-1:0] fill;
	logic reading;

	function automatic logic [AW-1:0] wrap_inc(input logic [AW-1:0] addr);
		return (addr == AW'(NUM_WORDS - 1)) ? '0 : addr + 1'b1;
	endfunction

	assign frame_full = (fill == CW'(FRAME_WORDS));

	// A write in the flush cycle still moves the frame
	assign start_next = (word_valid && frame_full) ? wrap_inc(start_addr) : start_addr;

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			write_addr <= '0;
			start_addr <= '0;
			fill <= '0;
		end else if (word_valid) begin
			write_addr <= wrap_inc(write_addr);
			start_addr <= start_next;
			if (!frame_full)
				fill <= fill + 1'b1; // Saturates at one frame
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			reading <= 1'b0;
			read_addr <= '0;
			play_index <= '0;
		end else if (play_restart) begin
			reading <= 1'b1;
			read_addr <= start_next;
			play_index <= '0;
		end else if (word_take && reading) begin
			if (play_index == IW'(FRAME_WORDS - 1)) begin
				read_addr <= start_addr; // Back to the oldest word
				play_index <= '0;
			end else begin
				read_addr <= wrap_inc(read_addr);
				play_index <= play_index + 1'b1;
			end
		end
	end

endmodule

// ==== mem_bank/word_packer.sv ====
`timescale 1ns/1ps

module word_packer
	import capture_cfg_pkg::*, capture_msg_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic capture_en,
	input logic clear,
	input in_sample_t capture_in,
	output ram_word_t word,
	output logic word_valid
);

	localparam int SW = (SAMPLES_PER_WORD > 1) ? $clog2(SAMPLES_PER_WORD) : 1;

	logic [SW-1:0] slot;
	logic take;

	assign take = capture_en && capture_in.valid;

	// Slot count drops to zero whenever capture stops
	always_ff @(posedge clk) begin
		if (reset || clear || !capture_en) begin
			slot <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (capture_in.valid) begin
				if (slot == SW'(SAMPLES_PER_WORD - 1)) begin
					slot <= '0;
					word_valid <= 1'b1; // Written next cycle
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

	// New sample enters at the top, oldest ends up at index 0
	always_ff @(posedge clk) begin
		if (take)
			word.samples <= {capture_in.sample, word.samples[SAMPLES_PER_WORD-1:1]};
	end

endmodule

// ==== mem_bank/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram
	import capture_cfg_pkg::*;
#(
	parameter int NUM_WORDS = 16,
	localparam int AW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
	input logic clk,
	input logic we,
	input logic [AW-1:0] write_addr,
	input logic [AW-1:0] read_addr,
	input ram_word_t wdata,
	output ram_word_t rdata
);

	logic [WORD_WIDTH-1:0] mem [NUM_WORDS];

	always_ff @(posedge clk) begin
		if (we)
			mem[write_addr] <= wdata.raw;
		rdata.raw <= mem[read_addr]; // One cycle read latency
	end

endmodule

// ==== mem_bank/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker
	import capture_cfg_pkg::*, capture_msg_pkg::*;
#(
	parameter int FRAME_WORDS = 4,
	localparam int IW = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1
) (
	input logic clk,
	input logic reset,
	input logic play_en,
	input logic play_restart,
	input ram_word_t rdata,
	input logic [IW-1:0] play_index,
	output logic word_take,
	output play_t play
);

	localparam int SW = (SAMPLES_PER_WORD > 1) ? $clog2(SAMPLES_PER_WORD) : 1;

	ram_word_t hold;
	logic [SW-1:0] remaining;
	logic last_word;
	logic out_valid;
	logic out_start;
	logic out_end;
	sample_t out_sample;

	assign word_take = play_en && (remaining == '0); // Current word spent
	assign play = '{valid: out_valid, frame_start: out_start, frame_end: out_end,
		sample: out_sample};

	always_ff @(posedge clk) begin
		if (reset || !play_en || play_restart) begin
			remaining <= '0;
			out_valid <= 1'b0;
			out_start <= 1'b0;
			out_end <= 1'b0;
		end else if (word_take) begin
			remaining <= SW'(SAMPLES_PER_WORD - 1);
			out_valid <= 1'b1;
			out_start <= (play_index == '0);
			out_end <= 1'b0;
		end else begin
			remaining <= remaining - 1'b1;
			out_valid <= 1'b1;
			out_start <= 1'b0;
			out_end <= last_word && (remaining == SW'(1));
		end
	end

	always_ff @(posedge clk) begin
		if (word_take) begin
			out_sample <= rdata.samples[0];
			hold.raw <= rdata.raw >> SAMPLE_WIDTH;
			last_word <= (play_index == IW'(FRAME_WORDS - 1));
		end else begin
			out_sample <= hold.samples[0];
			hold.raw <= hold.raw >> SAMPLE_WIDTH;
		end
	end

	// Frames follow back to back while playback runs
	assert property (@(posedge clk) disable iff (reset)
		play.frame_end |=> !play.valid || play.frame_start);

endmodule

// ==== logic/sample_capture_top.sv ====
`timescale 1ns/1ps

module sample_capture_top
	import capture_cfg_pkg::*, capture_msg_pkg::*;
#(
	parameter int NUM_WORDS = 16,
	parameter int FRAME_WORDS = 4,
	localparam int AW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1,
	localparam int IW = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1
) (
	input logic clk,
	input logic reset,
	input cmd_t cmd,
	output ack_t ack,
	input in_sample_t capture_in,
	output play_t play,
	output logic ready
);

	logic capture_en;
	logic clear;
	logic play_en;
	logic play_restart;
	logic frame_full;
	logic word_valid;
	logic word_take;
	logic [AW-1:0] write_addr;
	logic [AW-1:0] read_addr;
	logic [IW-1:0] play_index;
	ram_word_t word;
	ram_word_t rdata;

	assign ready = frame_full || (ack.mode == mode_playback);

	capture_sequencer i_capture_sequencer (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.frame_full(frame_full),
		.ack(ack),
		.capture_en(capture_en),
		.clear(clear),
		.play_en(play_en),
		.play_restart(play_restart)
	);

	frame_counter #(
		.NUM_WORDS(NUM_WORDS),
		.FRAME_WORDS(FRAME_WORDS)
	) i_frame_counter (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.word_valid(word_valid),
		.play_restart(play_restart),
		.word_take(word_take),
		.write_addr(write_addr),
		.read_addr(read_addr),
		.play_index(play_index),
		.frame_full(frame_full)
	);

	word_packer i_word_packer (
		.clk(clk),
		.reset(reset),
		.capture_en(capture_en),
		.clear(clear),
		.capture_in(capture_in),
		.word(word),
		.word_valid(word_valid)
	);

	sample_ram #(
		.NUM_WORDS(NUM_WORDS)
	) i_sample_ram (
		.clk(clk),
		.we(word_valid), // Every full word goes straight to the ring
		.write_addr(write_addr),
		.read_addr(read_addr),
		.wdata(word),
		.rdata(rdata)
	);

	word_unpacker #(
		.FRAME_WORDS(FRAME_WORDS)
	) i_word_unpacker (
		.clk(clk),
		.reset(reset),
		.play_en(play_en),
		.play_restart(play_restart),
		.rdata(rdata),
		.play_index(play_index),
		.word_take(word_take),
		.play(play)
	);

endmodule

// ==== verification/capture_tb_tasks.svh ====
`ifndef CAPTURE_TB_TASKS_SVH
`define CAPTURE_TB_TASKS_SVH

typedef sample_t sample_q_t[$];

task automatic abort_run();
	$display("ERRORS FOUND");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic report_timeout(input string what);
	$display("timeout at %0d ns: %s", $time, what);
	abort_run();
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_ack(input ack_t got, input ack_t exp, input string what);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s ack/accepted/mode is %b, expected %b",
			$time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_flag(input bit got, input bit exp, input string what);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

// Only whole words reach the ring, and the newest frame is what plays back
function automatic sample_q_t ref_frame(input sample_q_t sent);
	sample_q_t frame;
	int full_len;
	int i;
	full_len = (sent.size() / SAMPLES_PER_WORD) * SAMPLES_PER_WORD;
	for (i = full_len - FRAME_SAMPLES; i < full_len; i++)
		frame.push_back(sent[i]);
	return frame;
endfunction

`endif

// ==== verification/sample_capture_tb.sv ====
`timescale 1ns/1ps

module sample_capture_tb
	import capture_cfg_pkg::*, capture_msg_pkg::*;
();

	localparam int NUM_WORDS = 16;
	localparam int FRAME_WORDS = 4;
	localparam int FRAME_SAMPLES = FRAME_WORDS * SAMPLES_PER_WORD;
	localparam int CMD_TIMEOUT = 20;

	logic clk;
	logic reset;
	cmd_t cmd;
	ack_t ack;
	in_sample_t capture_in;
	play_t play;
	logic ready;

	integer seed = 32'hd0c71fd4;

	`include "capture_tb_tasks.svh"

	sample_q_t sent; // Samples since the last capture command
	sample_q_t expected;
	bit play_armed;
	int beat_idx;
	int frames_done;

	sample_capture_top #(
		.NUM_WORDS(NUM_WORDS),
		.FRAME_WORDS(FRAME_WORDS)
	) i_sample_capture_top (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.ack(ack),
		.capture_in(capture_in),
		.play(play),
		.ready(ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	// Four-phase req/ack, returns the ack seen while req was high
	task automatic run_command(input mode_t mode, output ack_t result);
		int n;
		cmd.mode = mode;
		step_cycle();
		cmd.req = 1'b1;
		n = 0;
		while (!ack.ack) begin
			if (n == CMD_TIMEOUT) begin
				report_timeout("ack did not rise after req");
			end else begin
				step_cycle();
				n++;
			end
		end
		result = ack;
		cmd.req = 1'b0;
		n = 0;
		while (ack.ack) begin
			if (n == CMD_TIMEOUT) begin
				report_timeout("ack did not fall after req dropped");
			end else begin
				step_cycle();
				n++;
			end
		end
	endtask

	task automatic send_samples(input int count);
		int i;
		int gap;
		for (i = 0; i < count; i++) begin
			gap = $unsigned($random(seed)) % 3; // Random idle cycles between samples
			capture_in.valid = 1'b0;
			repeat (gap) step_cycle();
			capture_in.valid = 1'b1;
			capture_in.sample = sample_t'($random(seed));
			sent.push_back(capture_in.sample);
			step_cycle();
		end
		capture_in.valid = 1'b0;
	endtask

	task automatic wait_frames(input int count);
		int n;
		n = 0;
		while (frames_done < count) begin
			if (n == 4 * FRAME_SAMPLES * (count + 1)) begin
				report_timeout("playback frames did not arrive");
			end else begin
				step_cycle();
				n++;
			end
		end
	endtask

	task automatic play_and_check();
		ack_t res;
		expected = ref_frame(sent);
		beat_idx = 0;
		frames_done = 0;
		play_armed = 1'b1;
		run_command(mode_playback, res);
		check_ack(res, '{ack: 1'b1, accepted: 1'b1, mode: mode_playback}, "playback command");
		wait_frames(3);
	endtask

	// Output compare on the falling edge, away from the DUT updates
	always @(negedge clk) begin
		if (!reset && play.valid === 1'b1) begin
			if (!play_armed) begin
				$display("a playback beat appeared at %0d ns while in capture mode", $time);
				abort_run();
			end else begin
				check_sample(play.sample, expected[beat_idx], "playback sample");
				check_flag(play.frame_start, beat_idx == 0, "frame_start");
				check_flag(play.frame_end, beat_idx == FRAME_SAMPLES - 1, "frame_end");
				if (ack.mode == mode_playback)
					check_flag(ready, 1'b1, "ready in playback");
				if (beat_idx == FRAME_SAMPLES - 1) begin
					beat_idx = 0;
					frames_done++;
				end else begin
					beat_idx++;
				end
			end
		end else if (!reset) begin
			check_flag(play.frame_start, 1'b0, "frame_start without valid");
			check_flag(play.frame_end, 1'b0, "frame_end without valid");
		end
	end

	initial begin
		ack_t res;
		int n;
		reset = 1'b1;
		cmd = '{req: 1'b0, mode: mode_capture};
		capture_in = '{valid: 1'b0, sample: '0};
		play_armed = 1'b0;
		beat_idx = 0;
		frames_done = 0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		check_flag(ack.ack, 1'b0, "ack after reset");
		check_flag(play.valid, 1'b0, "play.valid after reset");
		check_flag(ready, 1'b0, "ready after reset");
		run_command(mode_playback, res);
		check_ack(res, '{ack: 1'b1, accepted: 1'b0, mode: mode_capture}, "playback on empty ring");

		for (n = 0; n < FRAME_SAMPLES; n++) begin
			check_flag(ready, 1'b0, "ready before a full frame");
			send_samples(1);
		end
		n = 0;
		while (!ready && n < 2) begin
			step_cycle();
			n++;
		end
		check_flag(ready, 1'b1, "ready after a full frame");

		send_samples(2 * SAMPLES_PER_WORD + 5); // Ends in a partial word
		play_and_check();

		run_command(mode_capture, res);
		check_ack(res, '{ack: 1'b1, accepted: 1'b1, mode: mode_capture}, "capture command");
		play_armed = 1'b0;
		check_flag(ready, 1'b0, "ready after capture command");
		sent.delete();

		send_samples(3 * NUM_WORDS * SAMPLES_PER_WORD + 3); // Ring wraps three times
		play_and_check();

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== sample_capture.f ====
+incdir+verification
common/capture_cfg_pkg.sv
common/capture_msg_pkg.sv
logic/capture_sequencer.sv
logic/frame_counter.sv
mem_bank/word_packer.sv
mem_bank/sample_ram.sv
mem_bank/word_unpacker.sv
logic/sample_capture_top.sv
verification/sample_capture_tb.sv

// ==== Makefile ====
# Verilator build and run for the sample capture testbench
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= sample_capture_tb
FILELIST ?= sample_capture.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
